// File: list.f
+incdir+include
rtl/ram_rws_pkg.sv
rtl/ram_access_mux.sv
rtl/ram_2p_array.sv
rtl/mbist_capture.sv
rtl/ram_rws_128x64.sv
tb/tb_clock_gen.sv
tb/tb_ram_rws.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the result from sim.log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module tb_ram_rws \
  -Mdir obj_dir -o tb_ram_rws_sim > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_ram_rws_sim > sim.log 2>&1
grep -q "=== FAIL ===" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result, see sim.log"; exit 1; }
echo "simulation passed"

// File: tb/tb_ram_rws.sv
// testbench top with stimulus, array reference model, output compare and watchdog
`default_nettype none

`include "ram_rws_config.svh"

module tb_ram_rws;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RAND_OPS      = 200;
  localparam int INH_OPS       = 20;
  localparam int RDW_OPS       = 10;
  localparam int MBIST_OPS     = 40;
  localparam int CLK_PERIOD_NS = 40;
  localparam int MARGIN_CYCLES = 100;
  // reset, fill, the four phases, mbist entry, mbist sweep and drain
  localparam int TEST_CYCLES   = 3 + `RAM_DEPTH + RAND_OPS + 2 * INH_OPS + 2 * RDW_OPS
                                 + 7 + 2 * MBIST_OPS + `RAM_DEPTH + 5;

  logic                    clk;
  logic                    mbist_ramaccess_rst_;
  logic                    we;
  ram_rws_pkg::ram_addr_t  wa;
  ram_rws_pkg::ram_data_t  di;
  logic                    re;
  ram_rws_pkg::ram_addr_t  ra;
  logic                    write_inh;
  logic                    mbist_en;
  logic                    mbist_we;
  ram_rws_pkg::ram_addr_t  mbist_wa;
  ram_rws_pkg::mbist_pat_t mbist_pat;
  logic                    mbist_ce;
  ram_rws_pkg::ram_addr_t  mbist_ra;
  ram_rws_pkg::ram_data_t  dout;
  ram_rws_pkg::ram_data_t  mbist_dout;

  // reference array and pending expected words, each tagged with its check cycle
  ram_rws_pkg::ram_data_t model_mem [`RAM_DEPTH];
  int                     dout_due_q[$];
  ram_rws_pkg::ram_data_t dout_exp_q[$];
  int                     mbist_due_q[$];
  ram_rws_pkg::ram_data_t mbist_exp_q[$];
  int                     cyc = 0;
  int                     dout_errors = 0;
  int                     mbist_errors = 0;
  int                     reset_errors = 0;
  logic                   in_mbist = 1'b0;

  tb_clock_gen tb_clock_gen_i (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_)
  );

  ram_rws_128x64 ram_rws_128x64_i (.*);

  always @(posedge clk) cyc <= cyc + 1;

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  function automatic ram_rws_pkg::ram_data_t ref_read(input ram_rws_pkg::ram_addr_t a);
    return model_mem[a];
  endfunction

  // 2-bit pattern copied into every pair of bits
  function automatic ram_rws_pkg::ram_data_t pattern_word(input ram_rws_pkg::mbist_pat_t p);
    ram_rws_pkg::ram_data_t w;
    for (int i = 0; i < `RAM_DATA_W / `MBIST_PAT_W; i++) begin
      w[i * `MBIST_PAT_W +: `MBIST_PAT_W] = p;
    end
    return w;
  endfunction

  function automatic ram_rws_pkg::ram_addr_t rand_addr();
    return ram_rws_pkg::ram_addr_t'($urandom_range(`RAM_DEPTH - 1, 0));
  endfunction

  function automatic ram_rws_pkg::ram_data_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  // read sampled at the next edge shows on dout after it, capture one edge later
  task automatic expect_read(input ram_rws_pkg::ram_addr_t a, input logic via_mbist);
    dout_due_q.push_back(cyc + 2);
    dout_exp_q.push_back(ref_read(a));
    if (via_mbist) begin
      mbist_due_q.push_back(cyc + 3);
      mbist_exp_q.push_back(ref_read(a));
    end
  endtask

  // ----------------------------------------------------------------------
  // drivers
  // ----------------------------------------------------------------------
  task automatic func_cycle(input logic w, input ram_rws_pkg::ram_addr_t a_w,
                            input ram_rws_pkg::ram_data_t d, input logic r,
                            input ram_rws_pkg::ram_addr_t a_r, input logic inh);
    @(posedge clk);
    we        <= w;
    wa        <= a_w;
    di        <= d;
    re        <= r;
    ra        <= a_r;
    write_inh <= inh;
    mbist_we  <= 1'b0;
    mbist_ce  <= 1'b0;
    // read sees the array before a write of the same edge
    if (r && !in_mbist) begin
      expect_read(a_r, 1'b0);
    end
    if (w && !inh && !in_mbist) begin
      model_mem[a_w] = d;
    end
  endtask

  task automatic mbist_cycle(input logic w, input ram_rws_pkg::ram_addr_t a_w,
                             input ram_rws_pkg::mbist_pat_t p, input logic r,
                             input ram_rws_pkg::ram_addr_t a_r);
    @(posedge clk);
    mbist_we  <= w;
    mbist_wa  <= a_w;
    mbist_pat <= p;
    mbist_ce  <= r;
    mbist_ra  <= a_r;
    write_inh <= 1'b0;
    // functional port kept busy, it must not reach the array
    we <= 1'b1;
    wa <= rand_addr();
    di <= rand_word();
    re <= 1'b1;
    ra <= rand_addr();
    if (r) begin
      expect_read(a_r, 1'b1);
    end
    if (w) begin
      model_mem[a_w] = pattern_word(p);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) func_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0);
  endtask

  // ----------------------------------------------------------------------
  // compare
  // ----------------------------------------------------------------------
  always @(negedge clk) begin : compare_outputs
    ram_rws_pkg::ram_data_t exp_word;
    if (dout_due_q.size() > 0 && dout_due_q[0] == cyc) begin
      void'(dout_due_q.pop_front());
      exp_word = dout_exp_q.pop_front();
      assert (dout === exp_word) else begin
        dout_errors++;
        $display("ERROR %0t: dout is %h, expected %h", $time, dout, exp_word);
      end
    end
    if (mbist_due_q.size() > 0 && mbist_due_q[0] == cyc) begin
      void'(mbist_due_q.pop_front());
      exp_word = mbist_exp_q.pop_front();
      assert (mbist_dout === exp_word) else begin
        mbist_errors++;
        $display("ERROR %0t: mbist_dout is %h, expected %h", $time, mbist_dout, exp_word);
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin : stimulus
    ram_rws_pkg::ram_addr_t a;
    void'($urandom(4));
    we        = 1'b0;
    wa        = '0;
    di        = '0;
    re        = 1'b0;
    ra        = '0;
    write_inh = 1'b0;
    mbist_en  = 1'b0;
    mbist_we  = 1'b0;
    mbist_wa  = '0;
    mbist_pat = '0;
    mbist_ce  = 1'b0;
    mbist_ra  = '0;
    wait (mbist_ramaccess_rst_ === 1'b1);
    @(negedge clk);
    assert (dout === '0 && mbist_dout === '0) else begin
      reset_errors++;
      $display("ERROR %0t: outputs not zero after reset", $time);
    end
    // fill every word so later reads are defined
    for (int i = 0; i < `RAM_DEPTH; i++) begin
      func_cycle(1'b1, ram_rws_pkg::ram_addr_t'(i), rand_word(), 1'b0, '0, 1'b0);
    end
    for (int i = 0; i < RAND_OPS; i++) begin
      func_cycle($urandom_range(1, 0) != 0, rand_addr(), rand_word(),
                 $urandom_range(1, 0) != 0, rand_addr(), 1'b0);
    end
    for (int i = 0; i < INH_OPS; i++) begin
      a = rand_addr();
      func_cycle(1'b1, a, rand_word(), 1'b0, a, 1'b1);
      func_cycle(1'b0, a, '0, 1'b1, a, 1'b0);
    end
    // old word on the shared edge, new word one read later
    for (int i = 0; i < RDW_OPS; i++) begin
      a = rand_addr();
      func_cycle(1'b1, a, rand_word(), 1'b1, a, 1'b0);
      func_cycle(1'b0, a, '0, 1'b1, a, 1'b0);
    end
    idle_cycles(1);
    mbist_en <= 1'b1;
    idle_cycles(6);
    in_mbist = 1'b1;
    for (int i = 0; i < MBIST_OPS; i++) begin
      a = rand_addr();
      mbist_cycle(1'b1, a, ram_rws_pkg::mbist_pat_t'($urandom_range(3, 0)), 1'b0, '0);
      mbist_cycle(1'b0, '0, '0, 1'b1, a);
    end
    // back-to-back reads of every word, stray functional writes show up here
    for (int i = 0; i < `RAM_DEPTH; i++) begin
      mbist_cycle(1'b0, '0, '0, 1'b1, ram_rws_pkg::ram_addr_t'(i));
    end
    idle_cycles(3);
    while (dout_due_q.size() != 0 || mbist_due_q.size() != 0) begin
      @(negedge clk);
    end
    $display("errors: dout %0d, mbist_dout %0d, reset %0d",
             dout_errors, mbist_errors, reset_errors);
    if (dout_errors + mbist_errors + reset_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS);
    $display("test did not finish within %0d cycles, run stopped",
             TEST_CYCLES + MARGIN_CYCLES);
    $display("errors: dout %0d, mbist_dout %0d, reset %0d",
             dout_errors, mbist_errors, reset_errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// testbench clock source and power-on reset generator
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic mbist_ramaccess_rst_
);
  timeunit 1ns;
  timeprecision 1ps;

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset held low over the first 3 rising edges
  initial begin
    mbist_ramaccess_rst_ = 1'b0;
    repeat (3) @(posedge clk);
    mbist_ramaccess_rst_ <= 1'b1;
  end

endmodule

`default_nettype wire

// File: rtl/ram_rws_128x64.sv
// top level of the 128x64 ram with its mbist access path
`default_nettype none

module ram_rws_128x64 (
  input  wire                          clk,
  input  wire                          mbist_ramaccess_rst_,
  // functional port
  input  wire                          we,
  input  wire ram_rws_pkg::ram_addr_t  wa,
  input  wire ram_rws_pkg::ram_data_t  di,
  input  wire                          re,
  input  wire ram_rws_pkg::ram_addr_t  ra,
  input  wire                          write_inh,
  // mbist port
  input  wire                          mbist_en,
  input  wire                          mbist_we,
  input  wire ram_rws_pkg::ram_addr_t  mbist_wa,
  input  wire ram_rws_pkg::mbist_pat_t mbist_pat,
  input  wire                          mbist_ce,
  input  wire ram_rws_pkg::ram_addr_t  mbist_ra,
  // read data
  output ram_rws_pkg::ram_data_t       dout,
  output ram_rws_pkg::ram_data_t       mbist_dout
);

  logic                   arr_we;
  ram_rws_pkg::ram_addr_t arr_wa;
  ram_rws_pkg::ram_data_t arr_wdata;
  logic                   arr_re;
  ram_rws_pkg::ram_addr_t arr_ra;
  logic                   mbist_mode;
  logic                   mbist_rd;
  ram_rws_pkg::ram_data_t rd_data;

  // ----------------------------------------------------------------------
  // access selection
  // ----------------------------------------------------------------------
  ram_access_mux ram_access_mux_i (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .we                   (we),
    .wa                   (wa),
    .di                   (di),
    .re                   (re),
    .ra                   (ra),
    .write_inh            (write_inh),
    .mbist_en             (mbist_en),
    .mbist_we             (mbist_we),
    .mbist_wa             (mbist_wa),
    .mbist_pat            (mbist_pat),
    .mbist_ce             (mbist_ce),
    .mbist_ra             (mbist_ra),
    .arr_we               (arr_we),
    .arr_wa               (arr_wa),
    .arr_wdata            (arr_wdata),
    .arr_re               (arr_re),
    .arr_ra               (arr_ra),
    .mbist_mode           (mbist_mode),
    .mbist_rd             (mbist_rd)
  );

  // ----------------------------------------------------------------------
  // storage and mbist capture
  // ----------------------------------------------------------------------
  ram_2p_array ram_2p_array_i (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .arr_we               (arr_we),
    .arr_wa               (arr_wa),
    .arr_wdata            (arr_wdata),
    .arr_re               (arr_re),
    .arr_ra               (arr_ra),
    .rd_data              (rd_data)
  );

  mbist_capture mbist_capture_i (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .mbist_mode           (mbist_mode),
    .mbist_rd             (mbist_rd),
    .rd_data              (rd_data),
    .mbist_dout           (mbist_dout)
  );

  // functional read data comes straight off the read register
  assign dout = rd_data;

endmodule

`default_nettype wire

// File: rtl/mbist_capture.sv
// delayed mbist read strobe and the mbist data capture register
`default_nettype none

module mbist_capture (
  input  wire                         clk,
  input  wire                         mbist_ramaccess_rst_,
  input  wire                         mbist_mode,
  input  wire                         mbist_rd,
  input  wire ram_rws_pkg::ram_data_t rd_data,
  output ram_rws_pkg::ram_data_t      mbist_dout
);

  logic mbist_rd_d;

  // strobe lines up with the edge where rd_data already holds the word
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mbist_rd_d <= 1'b0;
    end else begin
      mbist_rd_d <= mbist_rd;
    end
  end

  // ----------------------------------------------------------------------
  // capture register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mbist_dout <= '0;
    end else if (mbist_rd_d && mbist_mode) begin
      mbist_dout <= rd_data;
    end
  end

  // leaving mbist mode freezes the last captured word, even with a read
  // strobe still in the delay flop
  a_hold_outside_mbist: assert property (
    @(posedge clk) disable iff (!mbist_ramaccess_rst_)
    !mbist_mode |=> $stable(mbist_dout)
  ) else $error("mbist_dout changed while mbist_mode was low");

endmodule

`default_nettype wire

// File: rtl/ram_2p_array.sv
// 128x64 storage with one synchronous write port and a registered read port
`default_nettype none

`include "ram_rws_config.svh"

module ram_2p_array (
  input  wire                         clk,
  input  wire                         mbist_ramaccess_rst_,
  input  wire                         arr_we,
  input  wire ram_rws_pkg::ram_addr_t arr_wa,
  input  wire ram_rws_pkg::ram_data_t arr_wdata,
  input  wire                         arr_re,
  input  wire ram_rws_pkg::ram_addr_t arr_ra,
  output ram_rws_pkg::ram_data_t      rd_data
);

  ram_rws_pkg::ram_data_t mem [`RAM_DEPTH];

  // ----------------------------------------------------------------------
  // write port
  // ----------------------------------------------------------------------
  // contents are not cleared by reset
  always_ff @(posedge clk) begin
    if (arr_we) begin
      mem[arr_wa] <= arr_wdata;
    end
  end

  // ----------------------------------------------------------------------
  // read port
  // ----------------------------------------------------------------------
  // same-edge write to arr_ra lands after this sample, so the old word
  // is returned
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      rd_data <= '0;
    end else if (arr_re) begin
      rd_data <= mem[arr_ra];
    end
  end

  // an enabled access needs a known address on its own port
  a_addr_known: assert property (
    @(posedge clk) disable iff (!mbist_ramaccess_rst_)
    (arr_we |-> !$isunknown(arr_wa)) and (arr_re |-> !$isunknown(arr_ra))
  ) else $error("array address unknown while its enable is high");

endmodule

`default_nettype wire

// File: rtl/ram_access_mux.sv
// mbist_en synchronizer, mode register and functional/mbist port selection
`default_nettype none

`include "ram_rws_config.svh"

module ram_access_mux (
  input  wire                         clk,
  input  wire                         mbist_ramaccess_rst_,
  // functional port
  input  wire                         we,
  input  wire ram_rws_pkg::ram_addr_t wa,
  input  wire ram_rws_pkg::ram_data_t di,
  input  wire                         re,
  input  wire ram_rws_pkg::ram_addr_t ra,
  input  wire                         write_inh,
  // mbist port
  input  wire                         mbist_en,
  input  wire                         mbist_we,
  input  wire ram_rws_pkg::ram_addr_t mbist_wa,
  input  wire ram_rws_pkg::mbist_pat_t mbist_pat,
  input  wire                         mbist_ce,
  input  wire ram_rws_pkg::ram_addr_t mbist_ra,
  // to the array
  output logic                        arr_we,
  output ram_rws_pkg::ram_addr_t      arr_wa,
  output ram_rws_pkg::ram_data_t      arr_wdata,
  output logic                        arr_re,
  output ram_rws_pkg::ram_addr_t      arr_ra,
  // to the capture register
  output logic                        mbist_mode,
  output logic                        mbist_rd
);

  logic [`MBIST_SYNC_STAGES-1:0] mbist_en_sync;
  logic                          sel_we;

  // ----------------------------------------------------------------------
  // mode entry
  // ----------------------------------------------------------------------
  // mbist_en is asynchronous to clk, so two flops before the mode register
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mbist_en_sync <= '0;
      mbist_mode    <= 1'b0;
    end else begin
      mbist_en_sync <= {mbist_en_sync[`MBIST_SYNC_STAGES-2:0], mbist_en};
      mbist_mode    <= mbist_en_sync[`MBIST_SYNC_STAGES-1];
    end
  end

  // ----------------------------------------------------------------------
  // port selection
  // ----------------------------------------------------------------------
  // functional enables are dropped entirely in mbist mode
  assign sel_we = mbist_mode ? mbist_we : we;

  // write_inh wins over both ports
  assign arr_we = sel_we & ~write_inh;
  assign arr_wa = mbist_mode ? mbist_wa : wa;

  // 2-bit pattern fills the whole word
  assign arr_wdata = mbist_mode ? {(`RAM_DATA_W / `MBIST_PAT_W){mbist_pat}} : di;

  assign arr_re = mbist_mode ? mbist_ce : re;
  assign arr_ra = mbist_mode ? mbist_ra : ra;

  // read strobe for the capture side, only meaningful in mbist mode
  assign mbist_rd = mbist_mode & mbist_ce;

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  // an inhibited edge never reaches the array
  a_write_inh_blocks: assert property (
    @(posedge clk) disable iff (!mbist_ramaccess_rst_)
    write_inh |-> !arr_we
  ) else $error("array write enabled while write_inh is high");

  // in mbist mode the functional we/re alone cannot start an access
  a_func_ignored_in_mbist: assert property (
    @(posedge clk) disable iff (!mbist_ramaccess_rst_)
    (mbist_mode && !mbist_we && !mbist_ce && (we || re)) |-> (!arr_we && !arr_re)
  ) else $error("functional enable leaked into the array in mbist mode");

endmodule

`default_nettype wire

// File: rtl/ram_rws_pkg.sv
// vector types shared by the ram, its mbist access path and the testbench
`default_nettype none

`include "ram_rws_config.svh"

package ram_rws_pkg;

  // word address into the array
  typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;

  // one stored word
  typedef logic [`RAM_DATA_W-1:0] ram_data_t;

  // mbist write pattern, replicated across a word
  typedef logic [`MBIST_PAT_W-1:0] mbist_pat_t;

endpackage

`default_nettype wire

// File: include/ram_rws_config.svh
// depth, width and mbist synchronizer macros for the 128x64 ram
`ifndef RAM_RWS_CONFIG_SVH
`define RAM_RWS_CONFIG_SVH

// ----------------------------------------------------------------------
// array geometry
// ----------------------------------------------------------------------
`define RAM_DEPTH 128
`define RAM_ADDR_W 7
`define RAM_DATA_W 64

// ----------------------------------------------------------------------
// mbist access
// ----------------------------------------------------------------------
// pattern is repeated RAM_DATA_W / MBIST_PAT_W times across a word
`define MBIST_PAT_W 2
// flops between mbist_en and the mode register
`define MBIST_SYNC_STAGES 2

`endif
